//--- logic/fabric_types_pkg.sv
// Fabric types
// Word, address and bank index types shared by the decoder, banks and merger

`default_nettype none

package fabric_types_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Upper limit for the number of banks
  localparam int MAX_BANKS = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Byte address from the requester
  typedef logic [ADDR_W-1:0] addr_t;
  // One full data word
  typedef logic [DATA_W-1:0] data_t;
  // Bank number, sized for MAX_BANKS
  typedef logic [$clog2(MAX_BANKS)-1:0] bank_idx_t;

endpackage

`default_nettype wire

//--- logic/mem_map_pkg.sv
// Memory map
// Base/mask region of the RAM banks and the address decode rules

`default_nettype none

package mem_map_pkg;

  // Bank 0 sits here, each further bank one window higher
  localparam fabric_types_pkg::addr_t BANK_REGION_BASE = 32'h0001_0000;
  localparam int BANK_WINDOW_BITS = 12;
  localparam int BYTE_OFS_BITS = 2;
  localparam fabric_types_pkg::addr_t BANK_REGION_MASK = {32{1'b1}} << BANK_WINDOW_BITS;

  // Window number relative to the base, wraps for addresses below it
  function automatic fabric_types_pkg::addr_t bank_window(fabric_types_pkg::addr_t addr);
    return ((addr & BANK_REGION_MASK) - BANK_REGION_BASE) >> BANK_WINDOW_BITS;
  endfunction

  function automatic logic bank_mapped(fabric_types_pkg::addr_t addr, int unsigned num_banks);
    return bank_window(addr) < fabric_types_pkg::addr_t'(num_banks);
  endfunction

  function automatic fabric_types_pkg::bank_idx_t bank_select(fabric_types_pkg::addr_t addr);
    return fabric_types_pkg::bank_idx_t'(bank_window(addr));
  endfunction

  // Word inside the bank, aliases beyond bank_words
  function automatic fabric_types_pkg::addr_t word_index(fabric_types_pkg::addr_t addr,
                                                         int unsigned bank_words);
    return (addr >> BYTE_OFS_BITS) & fabric_types_pkg::addr_t'(bank_words - 1);
  endfunction

endpackage

`default_nettype wire

//--- logic/bank_req_if.sv
// Bank request channel
// Single-cycle request strobe from the decoder, credit pulse back from the bank

`timescale 1ns/1ps
`default_nettype none

interface bank_req_if #(
  parameter int IDX_W = 6
);
  import fabric_types_pkg::*;

  logic             valid;
  logic             write;
  logic [IDX_W-1:0] idx;
  data_t            wdata;
  // One pulse per request popped by the bank
  logic             credit;

  modport decoder (output valid, output write, output idx, output wdata, input credit);

  modport bank (input valid, input write, input idx, input wdata, output credit);

endinterface

`default_nettype wire

//--- logic/req_decoder.sv
// Request decoder
// Buffers requester traffic, decodes the head address against the bank map
// and dispatches it when the target bank has credit and the route queue has room

`timescale 1ns/1ps
`default_nettype none

module req_decoder #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64,
  parameter int REQ_DEPTH  = 4,
  parameter int BANK_DEPTH = 2
) (
  input  logic                        hclk_i,
  input  logic                        rst_n_i,
  input  logic                        req_valid_i,
  input  logic                        req_write_i,
  input  fabric_types_pkg::addr_t     req_addr_i,
  input  fabric_types_pkg::data_t     req_wdata_i,
  output logic                        req_credit_o,
  bank_req_if.decoder                 bank_o [NUM_BANKS],
  output logic                        route_push_o,
  output logic                        route_err_o,
  output fabric_types_pkg::bank_idx_t route_bank_o,
  input  logic                        route_full_i
);
  import fabric_types_pkg::*;
  import mem_map_pkg::*;

  localparam int IDX_W = $clog2(BANK_WORDS);
  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);
  localparam int CRD_W = $clog2(BANK_DEPTH + 1);

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Request buffer
  logic             buf_write [REQ_DEPTH];
  addr_t            buf_addr  [REQ_DEPTH];
  data_t            buf_wdata [REQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Head decode
  addr_t            head_addr;
  addr_t            head_word;
  logic             head_mapped;
  bank_idx_t        head_bank;
  logic [IDX_W-1:0] head_idx;

  logic [CRD_W-1:0]     credit_cnt [NUM_BANKS];
  logic [NUM_BANKS-1:0] credit_in;
  logic [NUM_BANKS-1:0] bank_send;
  logic                 bank_ready;
  logic                 dispatch;

  ////////////////////////////////////////
  // Request buffer
  ////////////////////////////////////////

  always_ff @(posedge hclk_i) begin
    if (req_valid_i) begin
      buf_write[wr_ptr] <= req_write_i;
      buf_addr[wr_ptr]  <= req_addr_i;
      buf_wdata[wr_ptr] <= req_wdata_i;
    end
  end

  // Requester never overruns, it holds at most REQ_DEPTH credits
  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (dispatch) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + CNT_W'(req_valid_i) - CNT_W'(dispatch);
    end
  end

  ////////////////////////////////////////
  // Decode and dispatch
  ////////////////////////////////////////

  assign head_addr   = buf_addr[rd_ptr];
  assign head_mapped = bank_mapped(head_addr, NUM_BANKS);
  assign head_bank   = bank_select(head_addr);
  assign head_word   = word_index(head_addr, BANK_WORDS);
  assign head_idx    = head_word[IDX_W-1:0];

  always_comb begin
    bank_ready = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (head_bank == bank_idx_t'(b) && credit_cnt[b] != '0) begin
        bank_ready = 1'b1;
      end
    end
  end

  // Unmapped heads only need room in the route queue
  assign dispatch = (count != '0) && !route_full_i && (!head_mapped || bank_ready);

  assign req_credit_o = dispatch;
  assign route_push_o = dispatch;
  assign route_err_o  = !head_mapped;
  assign route_bank_o = head_bank;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign bank_send[b]    = dispatch && head_mapped && (head_bank == bank_idx_t'(b));
    assign bank_o[b].valid = bank_send[b];
    assign bank_o[b].write = buf_write[rd_ptr];
    assign bank_o[b].idx   = head_idx;
    assign bank_o[b].wdata = buf_wdata[rd_ptr];
    assign credit_in[b]    = bank_o[b].credit;
  end

  // Per-bank credits, one per free FIFO slot in the bank
  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        credit_cnt[b] <= CRD_W'(BANK_DEPTH);
      end
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        credit_cnt[b] <= credit_cnt[b] + CRD_W'(credit_in[b]) - CRD_W'(bank_send[b]);
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/sram_bank.sv
// RAM bank
// Queues requests from the decoder and executes one per cycle on a small
// word memory, results wait in a holding register until the merger takes them

`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
  parameter int BANK_WORDS = 64,
  parameter int BANK_DEPTH = 2
) (
  input  logic                    hclk_i,
  input  logic                    rst_n_i,
  bank_req_if.bank                req_i,
  output logic                    rsp_valid_o,
  output fabric_types_pkg::data_t rsp_rdata_o,
  input  logic                    rsp_take_i
);
  import fabric_types_pkg::*;

  localparam int IDX_W = $clog2(BANK_WORDS);
  localparam int PTR_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
  localparam int CNT_W = $clog2(BANK_DEPTH + 1);

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(BANK_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  logic             q_write [BANK_DEPTH];
  logic [IDX_W-1:0] q_idx   [BANK_DEPTH];
  data_t            q_wdata [BANK_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  data_t mem [BANK_WORDS];

  // Pop only when the holding register frees up this cycle
  assign pop = (count != '0) && (!rsp_valid_o || rsp_take_i);
  assign req_i.credit = pop;

  always_ff @(posedge hclk_i) begin
    if (req_i.valid) begin
      q_write[wr_ptr] <= req_i.write;
      q_idx[wr_ptr]   <= req_i.idx;
      q_wdata[wr_ptr] <= req_i.wdata;
    end
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_i.valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + CNT_W'(req_i.valid) - CNT_W'(pop);
    end
  end

  ////////////////////////////////////////
  // Memory and holding register
  ////////////////////////////////////////

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (pop && q_write[rd_ptr]) begin
      mem[q_idx[rd_ptr]] <= q_wdata[rd_ptr];
    end
  end

  // Writes answer with zero data
  always_ff @(posedge hclk_i) begin
    if (pop) begin
      rsp_rdata_o <= q_write[rd_ptr] ? '0 : mem[q_idx[rd_ptr]];
    end
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else if (pop) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_take_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/rsp_merger.sv
// Response merger
// Holds the route of every dispatched request and drains bank responses
// strictly in that order, unmapped routes become error responses

`timescale 1ns/1ps
`default_nettype none

module rsp_merger #(
  parameter int NUM_BANKS   = 4,
  parameter int ORDER_DEPTH = 8
) (
  input  logic                        hclk_i,
  input  logic                        rst_n_i,
  input  logic                        route_push_i,
  input  logic                        route_err_i,
  input  fabric_types_pkg::bank_idx_t route_bank_i,
  output logic                        route_full_o,
  input  logic [NUM_BANKS-1:0]        bank_valid_i,
  input  fabric_types_pkg::data_t     bank_rdata_i [NUM_BANKS],
  output logic [NUM_BANKS-1:0]        bank_take_o,
  output logic                        rsp_valid_o,
  output logic                        rsp_err_o,
  output fabric_types_pkg::data_t     rsp_rdata_o
);
  import fabric_types_pkg::*;

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  logic             q_err  [ORDER_DEPTH];
  bank_idx_t        q_bank [ORDER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;
  data_t            head_rdata;

  assign route_full_o = (count == CNT_W'(ORDER_DEPTH));

  always_ff @(posedge hclk_i) begin
    if (route_push_i) begin
      q_err[wr_ptr]  <= route_err_i;
      q_bank[wr_ptr] <= route_bank_i;
    end
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (route_push_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + CNT_W'(route_push_i) - CNT_W'(pop);
    end
  end

  ////////////////////////////////////////
  // Head of queue
  ////////////////////////////////////////

  // Only the bank named at the head is ever taken from
  always_comb begin
    pop         = 1'b0;
    head_rdata  = '0;
    bank_take_o = '0;
    if (count != '0) begin
      if (q_err[rd_ptr]) begin
        pop = 1'b1;
      end else begin
        for (int b = 0; b < NUM_BANKS; b++) begin
          if (q_bank[rd_ptr] == bank_idx_t'(b) && bank_valid_i[b]) begin
            bank_take_o[b] = 1'b1;
            head_rdata     = bank_rdata_i[b];
            pop            = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge hclk_i) begin
    if (pop) begin
      rsp_err_o   <= q_err[rd_ptr];
      rsp_rdata_o <= head_rdata;
    end
  end

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= pop;
    end
  end

endmodule

`default_nettype wire

//--- logic/mem_fabric_top.sv
// Memory fabric top
// One requester port routed by address to NUM_BANKS RAM banks,
// responses come back in request order

`timescale 1ns/1ps
`default_nettype none

module mem_fabric_top #(
  parameter int NUM_BANKS   = 4,
  parameter int BANK_WORDS  = 64,
  parameter int REQ_DEPTH   = 4,
  parameter int BANK_DEPTH  = 2,
  parameter int ORDER_DEPTH = 8
) (
  input  logic                    hclk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  logic                    req_write_i,
  input  fabric_types_pkg::addr_t req_addr_i,
  input  fabric_types_pkg::data_t req_wdata_i,
  output logic                    req_credit_o,
  output logic                    rsp_valid_o,
  output logic                    rsp_err_o,
  output fabric_types_pkg::data_t rsp_rdata_o
);
  import fabric_types_pkg::*;

  localparam int IDX_W = $clog2(BANK_WORDS);

  logic                 route_push;
  logic                 route_err;
  bank_idx_t            route_bank;
  logic                 route_full;
  logic [NUM_BANKS-1:0] bank_valid;
  data_t                bank_rdata [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_take;

  bank_req_if #(.IDX_W(IDX_W)) bank_if [NUM_BANKS] ();

  req_decoder #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS),
    .REQ_DEPTH (REQ_DEPTH),
    .BANK_DEPTH(BANK_DEPTH)
  ) u_decoder (
    .hclk_i      (hclk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_credit_o(req_credit_o),
    .bank_o      (bank_if),
    .route_push_o(route_push),
    .route_err_o (route_err),
    .route_bank_o(route_bank),
    .route_full_i(route_full)
  );

  // One RAM bank per window
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    sram_bank #(
      .BANK_WORDS(BANK_WORDS),
      .BANK_DEPTH(BANK_DEPTH)
    ) u_bank (
      .hclk_i     (hclk_i),
      .rst_n_i    (rst_n_i),
      .req_i      (bank_if[b]),
      .rsp_valid_o(bank_valid[b]),
      .rsp_rdata_o(bank_rdata[b]),
      .rsp_take_i (bank_take[b])
    );
  end

  rsp_merger #(
    .NUM_BANKS  (NUM_BANKS),
    .ORDER_DEPTH(ORDER_DEPTH)
  ) u_merger (
    .hclk_i      (hclk_i),
    .rst_n_i     (rst_n_i),
    .route_push_i(route_push),
    .route_err_i (route_err),
    .route_bank_i(route_bank),
    .route_full_o(route_full),
    .bank_valid_i(bank_valid),
    .bank_rdata_i(bank_rdata),
    .bank_take_o (bank_take),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

endmodule

`default_nettype wire

//--- dv/mem_fabric_assertions.sv
// Fabric checks
// Bank credit bounds, bank FIFO room on every send and quiet outputs during reset

`timescale 1ns/1ps
`default_nettype none

module mem_fabric_assertions #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 2,
  parameter int CRD_W      = $clog2(BANK_DEPTH + 1)
) (
  input logic                 hclk_i,
  input logic                 rst_n_i,
  input logic [CRD_W-1:0]     credit_cnt_i [NUM_BANKS],
  input logic [NUM_BANKS-1:0] bank_send_i,
  input logic [NUM_BANKS-1:0] bank_credit_i,
  input logic                 req_credit_i,
  input logic                 rsp_valid_i
);

  localparam int FILL_W = CRD_W + 1;

  // Requests held in each bank FIFO, counted from sends and credit pulses
  logic [FILL_W-1:0] fifo_fill [NUM_BANKS];

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        fifo_fill[b] <= '0;
      end
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        fifo_fill[b] <= fifo_fill[b] + FILL_W'(bank_send_i[b]) - FILL_W'(bank_credit_i[b]);
      end
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    credit_bound: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      credit_cnt_i[b] <= CRD_W'(BANK_DEPTH))
      else $error("bank %0d credit counter above its FIFO depth", b);

    send_with_credit: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      bank_send_i[b] |-> fifo_fill[b] < FILL_W'(BANK_DEPTH))
      else $error("request sent to bank %0d with its FIFO already full", b);
  end

  quiet_in_reset: assert property (@(posedge hclk_i) !rst_n_i |-> !rsp_valid_i && !req_credit_i)
    else $error("response or credit strobe active during reset");

endmodule

bind mem_fabric_top mem_fabric_assertions #(
  .NUM_BANKS (NUM_BANKS),
  .BANK_DEPTH(BANK_DEPTH)
) assertions_i (
  .hclk_i       (hclk_i),
  .rst_n_i      (rst_n_i),
  .credit_cnt_i (u_decoder.credit_cnt),
  .bank_send_i  (u_decoder.bank_send),
  .bank_credit_i(u_decoder.credit_in),
  .req_credit_i (req_credit_o),
  .rsp_valid_i  (rsp_valid_o)
);

`default_nettype wire

//--- dv/mem_fabric_tb.sv
// Memory fabric testbench
// Directed tests checked in order against a reference model of the bank map

`timescale 1ns/1ps
`default_nettype none

module mem_fabric_tb;
  import fabric_types_pkg::*;
  import mem_map_pkg::*;

  localparam int NUM_BANKS    = 4;
  localparam int BANK_WORDS   = 64;
  localparam int REQ_DEPTH    = 4;
  localparam int BANK_DEPTH   = 2;
  localparam int ORDER_DEPTH  = 8;
  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int RAND_SEED    = 292;
  localparam int RANDOM_REQS  = 200;
  localparam int WINDOW_WORDS = 1 << (BANK_WINDOW_BITS - BYTE_OFS_BITS);
  // Requests issued by all tests together
  localparam int TOTAL_REQS = NUM_BANKS * BANK_WORDS + 20 + 10 + 6 + 3 * REQ_DEPTH + RANDOM_REQS;

  logic  hclk;
  logic  rst_n;
  logic  req_valid;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;
  logic  req_credit;
  logic  rsp_valid;
  logic  rsp_err;
  data_t rsp_rdata;

  // Reference model, keyed by bank * BANK_WORDS + word
  data_t           model_mem [int];
  logic [DATA_W:0] exp_q [$];
  int              credits = REQ_DEPTH;
  int              credit_pulses = 0;
  int              errors = 0;
  int              checks = 0;
  int              tests = 0;
  int              test_err_start = 0;
  string           test_name = "reset";

  mem_fabric_top #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS),
    .REQ_DEPTH  (REQ_DEPTH),
    .BANK_DEPTH (BANK_DEPTH),
    .ORDER_DEPTH(ORDER_DEPTH)
  ) dut_i (
    .hclk_i      (hclk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_credit_o(req_credit),
    .rsp_valid_o (rsp_valid),
    .rsp_err_o   (rsp_err),
    .rsp_rdata_o (rsp_rdata)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  ////////////////////////////////////////
  // Model and helpers
  ////////////////////////////////////////

  function automatic logic addr_mapped(addr_t addr);
    return addr >= BANK_REGION_BASE &&
           addr < BANK_REGION_BASE + (addr_t'(NUM_BANKS) << BANK_WINDOW_BITS);
  endfunction

  function automatic int model_key(addr_t addr);
    int bank;
    int word;
    bank = int'((addr - BANK_REGION_BASE) >> BANK_WINDOW_BITS);
    word = int'(addr >> BYTE_OFS_BITS) % BANK_WORDS;
    return bank * BANK_WORDS + word;
  endfunction

  function automatic addr_t bank_addr(int bank, int word);
    return BANK_REGION_BASE + addr_t'(bank << BANK_WINDOW_BITS) + addr_t'(word << BYTE_OFS_BITS);
  endfunction

  task automatic compare_value(input string what, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // Called just after a rising edge, holds the request for one cycle
  task automatic send_req(input logic is_write, input addr_t addr, input data_t wdata);
    logic  err;
    data_t rdata;
    while (credits == 0) begin
      @(posedge hclk);
      #(DRIVE_DELAY);
    end
    err   = !addr_mapped(addr);
    rdata = '0;
    if (!err && is_write) begin
      model_mem[model_key(addr)] = wdata;
    end else if (!err && model_mem.exists(model_key(addr))) begin
      rdata = model_mem[model_key(addr)];
    end
    exp_q.push_back({err, rdata});
    credits--;
    req_valid = 1'b1;
    req_write = is_write;
    req_addr  = addr;
    req_wdata = wdata;
    @(posedge hclk);
    #(DRIVE_DELAY);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge hclk);
    end
    @(posedge hclk);
    #(DRIVE_DELAY);
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    drain();
    tests++;
    $display("test %s: %0d errors", test_name, errors - test_err_start);
  endtask

  // Credit pulses and responses, sampled mid-cycle
  always @(negedge hclk) begin : rsp_monitor
    logic [DATA_W:0] exp_rsp;
    if (req_credit) begin
      credits++;
      credit_pulses++;
    end
    if (rsp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response in %s arrived with no request outstanding", test_name);
      end else begin
        exp_rsp = exp_q.pop_front();
        compare_value("error flag", DATA_W'(exp_rsp[DATA_W]), DATA_W'(rsp_err));
        compare_value("read data", exp_rsp[DATA_W-1:0], rsp_rdata);
      end
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    start_test("reset_state");
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        send_req(1'b0, bank_addr(b, w), '0);
      end
    end
    end_test();
  endtask

  task automatic test_write_read();
    start_test("write_read");
    for (int i = 0; i < 8; i++) begin
      send_req(1'b1, bank_addr(i % NUM_BANKS, i * 3), $urandom());
    end
    // Overwrite half of them
    for (int i = 0; i < 4; i++) begin
      send_req(1'b1, bank_addr(i % NUM_BANKS, i * 3), $urandom());
    end
    for (int i = 0; i < 8; i++) begin
      send_req(1'b0, bank_addr(i % NUM_BANKS, i * 3), '0);
    end
    end_test();
  endtask

  task automatic test_bank_independence();
    start_test("bank_independence");
    for (int b = 0; b < NUM_BANKS; b++) begin
      send_req(1'b1, bank_addr(b, 5), 32'hBA00_0000 + data_t'(b) * 32'h1111);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      send_req(1'b0, bank_addr(b, 5), '0);
    end
    // Word BANK_WORDS + 5 lands on word 5
    send_req(1'b1, bank_addr(0, BANK_WORDS + 5), 32'h0A11_A5ED);
    send_req(1'b0, bank_addr(0, 5), '0);
    end_test();
  endtask

  task automatic test_unmapped();
    start_test("unmapped");
    send_req(1'b0, bank_addr(1, 5), '0);
    send_req(1'b0, BANK_REGION_BASE - 32'd4, '0);
    send_req(1'b1, bank_addr(NUM_BANKS, 0), 32'hDEAD_BEEF);
    send_req(1'b0, bank_addr(2, 5), '0);
    send_req(1'b0, 32'hFFFF_FFFC, '0);
    send_req(1'b1, bank_addr(3, 7), 32'h1234_5678);
    end_test();
  endtask

  task automatic test_credits();
    int pulses_start;
    int bank;
    start_test("credits");
    // Spread writes, spread reads, then reads piled on one bank
    for (int round = 0; round < 3; round++) begin
      pulses_start = credit_pulses;
      for (int i = 0; i < REQ_DEPTH; i++) begin
        bank = (round == 2) ? 0 : i % NUM_BANKS;
        send_req(round == 0, bank_addr(bank, 10 + i), $urandom());
      end
      drain();
      compare_value("credit pulses", REQ_DEPTH, credit_pulses - pulses_start);
      compare_value("credits held", REQ_DEPTH, credits);
    end
    end_test();
  endtask

  task automatic test_random_mix();
    addr_t addr;
    int    kind;
    start_test("random_mix");
    for (int n = 0; n < RANDOM_REQS; n++) begin
      kind = $urandom_range(0, 9);
      if (kind < 8) begin
        addr = bank_addr($urandom_range(0, NUM_BANKS - 1), $urandom_range(0, WINDOW_WORDS - 1));
      end else if (kind == 8) begin
        addr = ($urandom() % BANK_REGION_BASE) & ~addr_t'(3);
      end else begin
        addr = (bank_addr(NUM_BANKS, 0) + ($urandom() % 32'h0010_0000)) & ~addr_t'(3);
      end
      send_req(1'($urandom_range(0, 1)), addr, $urandom());
    end
    end_test();
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    repeat (2) @(posedge hclk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    test_reset_state();
    test_write_read();
    test_bank_independence();
    test_unmapped();
    test_credits();
    test_random_mix();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog, 40 cycles per request
  initial begin
    #(TOTAL_REQS * 40 * CLK_PERIOD);
    $display("timeout in %s, responses still outstanding", test_name);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
logic/fabric_types_pkg.sv
logic/mem_map_pkg.sv
logic/bank_req_if.sv
logic/req_decoder.sv
logic/sram_bank.sv
logic/rsp_merger.sv
logic/mem_fabric_top.sv
dv/mem_fabric_assertions.sv
dv/mem_fabric_tb.sv

//--- Makefile
# Verilator build, run and lint for the memory fabric

VERILATOR ?= verilator
TOP       ?= mem_fabric_tb
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# The log decides the result, the simulator exit code is not used
run: build
	$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
